// ==== src/lcd_defs.svh ====
`ifndef LCD_DEFS_SVH
`define LCD_DEFS_SVH

// clocks per microsecond, kept small for simulation
`define LCD_CLK_PER_US 2

// waits in microseconds
`define LCD_T_POWERUP 500
`define LCD_T_CMD 50
`define LCD_T_CLEAR 200
`define LCD_T_ENTRY 100
`define LCD_T_INIT_E 10          // enable width during init
`define LCD_T_E_START 1          // enable rise inside a command window
`define LCD_T_E_END 14           // enable fall inside a command window

`define LCD_LINE_CHARS 16

// two lines, display on, increment
`define LCD_CFG_DEFAULT 7'b1010010

`define LCD_ADDR_CFG 5'h00
`define LCD_ADDR_CMD 5'h04
`define LCD_ADDR_STATUS 5'h08
`define LCD_ADDR_LINE 5'h0C
`define LCD_ADDR_CHAR0 5'h10     // char words at 0x10..0x1C

`endif

// ==== src/lcd_pkg.sv ====
`include "lcd_defs.svh"

package lcd_pkg;

	// display configuration, same bit order as the init word
	typedef struct packed {
		logic two_line;
		logic font;
		logic display_on;
		logic cursor_on;
		logic blink_on;
		logic increment;
		logic shift;
	} lcd_cfg_t;

	typedef struct packed {
		logic       rs;
		logic       rw;
		logic [7:0] data;
	} lcd_cmd_t;

	typedef logic [`LCD_LINE_CHARS-1:0][7:0] lcd_line_t;   // char 0 in the low byte

	typedef struct packed {
		logic init_done;
		logic busy;
		logic line_active;
	} lcd_status_t;

endpackage

// ==== src/lcd_hd44780_ctrl.sv ====
`include "lcd_defs.svh"

module lcd_hd44780_ctrl (
	input  logic                clk,
	input  logic                rst,
	input  lcd_pkg::lcd_cfg_t   cfg,
	input  logic                eng_valid,
	input  lcd_pkg::lcd_cmd_t   eng_cmd,
	output logic                eng_ready,
	output logic                init_done,
	output logic                busy,
	output logic                e,
	output logic                rs,
	output logic                rw,
	output logic [7:0]          lcd_data
);
	import lcd_pkg::*;

	localparam int T       = `LCD_CLK_PER_US;
	localparam int PWR_CYC = `LCD_T_POWERUP * T;
	localparam int CW      = $clog2(PWR_CYC + 1);   // power-up is the longest wait

	localparam logic [CW-1:0] PWR_LAST     = CW'(PWR_CYC - 1);
	localparam logic [CW-1:0] EXEC_LAST    = CW'(`LCD_T_CMD * T - 1);
	localparam logic [CW-1:0] INIT_E_END   = CW'(`LCD_T_INIT_E * T);
	localparam logic [CW-1:0] EXEC_E_START = CW'(`LCD_T_E_START * T);
	localparam logic [CW-1:0] EXEC_E_END   = CW'(`LCD_T_E_END * T);

	typedef enum logic [1:0] {
		ST_PWRUP,
		ST_INIT,
		ST_IDLE,
		ST_EXEC
	} state_t;

	state_t        state;
	logic [CW-1:0] cnt;
	logic [1:0]    step;     // init command index
	lcd_cmd_t      cmd_q;    // drives the bus for the whole window

	// the four init commands built from the cfg bits
	function automatic lcd_cmd_t init_cmd(input logic [1:0] idx, input lcd_cfg_t c);
		lcd_cmd_t cmd;
		cmd.rs = 1'b0;
		cmd.rw = 1'b0;
		case (idx)
			2'd0: cmd.data = {4'b0011, c.two_line, c.font, 2'b00};       // function set
			2'd1: cmd.data = {5'b00001, c.display_on, c.cursor_on, c.blink_on};
			2'd2: cmd.data = 8'h01;                                      // clear
			default: cmd.data = {6'b000001, c.increment, c.shift};       // entry mode
		endcase
		return cmd;
	endfunction

	// last count of each init window
	function automatic logic [CW-1:0] init_last(input logic [1:0] idx);
		case (idx)
			2'd0, 2'd1: return CW'((`LCD_T_INIT_E + `LCD_T_CMD) * T - 1);
			2'd2: return CW'((`LCD_T_INIT_E + `LCD_T_CLEAR) * T - 1);
			default: return CW'((`LCD_T_INIT_E + `LCD_T_ENTRY) * T - 1);
		endcase
	endfunction

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= ST_PWRUP;
			cnt       <= '0;
			step      <= 2'd0;
			cmd_q     <= '0;
			init_done <= 1'b0;
		end else begin
			case (state)
				ST_PWRUP: begin
					if (cnt == PWR_LAST) begin
						cnt   <= '0;
						step  <= 2'd0;
						cmd_q <= init_cmd(2'd0, cfg);
						state <= ST_INIT;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				ST_INIT: begin
					if (cnt == init_last(step)) begin
						cnt <= '0;
						if (step == 2'd3) begin
							cmd_q     <= '0;
							init_done <= 1'b1;
							state     <= ST_IDLE;
						end else begin
							step  <= step + 1'b1;
							cmd_q <= init_cmd(step + 1'b1, cfg);   // latch next init word
						end
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				ST_IDLE: begin
					cnt <= '0;
					if (eng_valid) begin
						cmd_q <= eng_cmd;
						state <= ST_EXEC;
					end
				end
				default: begin
					if (cnt == EXEC_LAST) begin
						cnt   <= '0;
						cmd_q <= '0;
						state <= ST_IDLE;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
			endcase
		end
	end

	// enable shaping per window
	always_comb begin
		case (state)
			ST_INIT: e = (cnt < INIT_E_END);
			ST_EXEC: e = (cnt >= EXEC_E_START) && (cnt < EXEC_E_END);
			default: e = 1'b0;
		endcase
	end

	assign eng_ready = (state == ST_IDLE);
	assign busy      = (state != ST_IDLE);
	assign rs        = cmd_q.rs;
	assign rw        = cmd_q.rw;
	assign lcd_data  = cmd_q.data;

endmodule

// ==== src/lcd_cmd_arbiter.sv ====
module lcd_cmd_arbiter (
	input  logic                    clk,
	input  logic                    rst,
	input  logic [1:0]              req_valid,
	input  lcd_pkg::lcd_cmd_t [1:0] req_cmd,
	input  logic                    eng_ready,
	output logic [1:0]              req_ready,
	output logic                    eng_valid,
	output lcd_pkg::lcd_cmd_t       eng_cmd
);

	logic last;   // index served last
	logic sel;    // index granted this cycle

	// the other requester wins a tie, a lone request goes through at once
	always_comb begin
		if (&req_valid) begin
			sel = ~last;
		end else begin
			sel = req_valid[1];
		end
	end

	assign eng_valid    = |req_valid;
	assign eng_cmd      = req_cmd[sel];
	assign req_ready[0] = eng_ready & req_valid[0] & ~sel;
	assign req_ready[1] = eng_ready & req_valid[1] & sel;

	always_ff @(posedge clk) begin
		if (rst) begin
			last <= 1'b1;   // requester 0 first on a tie
		end else if (eng_valid && eng_ready) begin
			last <= sel;
		end
	end

endmodule

// ==== src/lcd_axil_regs.sv ====
`include "lcd_defs.svh"

module lcd_axil_regs (
	input  logic                clk,
	input  logic                rst,
	input  logic                awvalid,
	input  logic [4:0]          awaddr,
	input  logic                wvalid,
	input  logic [31:0]         wdata,
	input  logic [3:0]          wstrb,
	input  logic                bready,
	input  logic                arvalid,
	input  logic [4:0]          araddr,
	input  logic                rready,
	input  logic                cmd_req_ready,
	input  logic                init_done,
	input  logic                busy,
	input  logic                line_active,
	output logic                awready,
	output logic                wready,
	output logic                bvalid,
	output logic [1:0]          bresp,
	output logic                arready,
	output logic                rvalid,
	output logic [31:0]         rdata,
	output logic [1:0]          rresp,
	output lcd_pkg::lcd_cfg_t   cfg,
	output logic                cmd_req_valid,
	output lcd_pkg::lcd_cmd_t   cmd_req,
	output lcd_pkg::lcd_line_t  line_buf,
	output logic                line_sel,
	output logic                line_start
);
	import lcd_pkg::*;

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	logic        wr_hs;
	logic        wr_ok;
	logic        wr_char;
	logic        ar_hs;
	logic        rd_ok;
	logic [31:0] rd_data;
	lcd_status_t status;

	// one write in flight, B waits for the command handoff
	assign awready = awvalid & wvalid & ~bvalid & ~cmd_req_valid;
	assign wready  = awready;
	assign wr_hs   = awready;
	assign arready = ~rvalid;
	assign ar_hs   = arvalid & arready;

	assign status = '{init_done: init_done, busy: busy, line_active: line_active};

	always_comb begin
		wr_ok   = 1'b1;
		wr_char = 1'b0;
		case (awaddr)
			`LCD_ADDR_CFG, `LCD_ADDR_CMD, `LCD_ADDR_STATUS, `LCD_ADDR_LINE: wr_ok = 1'b1;
			`LCD_ADDR_CHAR0, `LCD_ADDR_CHAR0 + 5'h04,
			`LCD_ADDR_CHAR0 + 5'h08, `LCD_ADDR_CHAR0 + 5'h0C: wr_char = 1'b1;
			default: wr_ok = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			cfg           <= lcd_cfg_t'(`LCD_CFG_DEFAULT);
			cmd_req_valid <= 1'b0;
			bvalid        <= 1'b0;
			bresp         <= RESP_OKAY;
			line_sel      <= 1'b0;
			line_start    <= 1'b0;
		end else begin
			line_start <= 1'b0;
			if (bvalid && bready) bvalid <= 1'b0;
			if (cmd_req_valid && cmd_req_ready) begin   // arbiter took it, release B
				cmd_req_valid <= 1'b0;
				bvalid        <= 1'b1;
				bresp         <= RESP_OKAY;
			end
			if (wr_hs) begin
				if (awaddr == `LCD_ADDR_CMD) begin
					cmd_req_valid <= 1'b1;
				end else begin
					bvalid <= 1'b1;
					bresp  <= wr_ok ? RESP_OKAY : RESP_SLVERR;
				end
				if (awaddr == `LCD_ADDR_CFG && wstrb[0]) cfg <= lcd_cfg_t'(wdata[6:0]);
				if (awaddr == `LCD_ADDR_LINE) begin
					line_start <= wdata[0];
					line_sel   <= wdata[1];
				end
			end
		end
	end

	// payload storage
	always_ff @(posedge clk) begin
		if (wr_hs && awaddr == `LCD_ADDR_CMD) cmd_req <= lcd_cmd_t'(wdata[9:0]);
		if (wr_hs && wr_char) begin
			for (int j = 0; j < 4; j++) begin
				if (wstrb[j]) line_buf[{awaddr[3:2], 2'(j)}] <= wdata[8*j +: 8];
			end
		end
	end

	always_comb begin
		rd_ok   = 1'b1;
		rd_data = '0;
		case (araddr)
			`LCD_ADDR_CFG: rd_data[6:0] = cfg;
			`LCD_ADDR_CMD: rd_data[9:0] = cmd_req;
			`LCD_ADDR_STATUS: rd_data[2:0] = status;
			`LCD_ADDR_LINE: rd_data[1] = line_sel;
			`LCD_ADDR_CHAR0, `LCD_ADDR_CHAR0 + 5'h04,
			`LCD_ADDR_CHAR0 + 5'h08, `LCD_ADDR_CHAR0 + 5'h0C: begin
				for (int j = 0; j < 4; j++) begin
					rd_data[8*j +: 8] = line_buf[{araddr[3:2], 2'(j)}];
				end
			end
			default: rd_ok = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rvalid <= 1'b0;
		end else if (ar_hs) begin
			rvalid <= 1'b1;
		end else if (rready) begin
			rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (ar_hs) begin
			rdata <= rd_data;
			rresp <= rd_ok ? RESP_OKAY : RESP_SLVERR;
		end
	end

endmodule

// ==== src/lcd_line_writer.sv ====
`include "lcd_defs.svh"

module lcd_line_writer (
	input  logic                clk,
	input  logic                rst,
	input  lcd_pkg::lcd_line_t  line_buf,
	input  logic                line_sel,
	input  logic                line_start,
	input  logic                cmd_ready,
	output logic                cmd_valid,
	output lcd_pkg::lcd_cmd_t   cmd,
	output logic                line_active
);
	import lcd_pkg::*;

	localparam int NCMD = `LCD_LINE_CHARS + 1;     // address then chars
	localparam int IW   = $clog2(NCMD);
	localparam int CW   = $clog2(`LCD_LINE_CHARS);

	localparam logic [IW-1:0] IDX_LAST = IW'(`LCD_LINE_CHARS);

	lcd_line_t     buf_q;     // snapshot of the host buffer
	logic          sel_q;
	logic [IW-1:0] idx;       // 0 is the address command
	logic [CW-1:0] char_idx;

	assign char_idx  = CW'(idx - 1'b1);
	assign cmd_valid = line_active;

	always_comb begin
		if (idx == '0) begin
			cmd.rs   = 1'b0;
			cmd.rw   = 1'b0;
			cmd.data = sel_q ? 8'hC0 : 8'h80;   // set DDRAM address
		end else begin
			cmd.rs   = 1'b1;
			cmd.rw   = 1'b0;
			cmd.data = buf_q[char_idx];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			line_active <= 1'b0;
			idx         <= '0;
		end else if (!line_active) begin
			if (line_start) begin     // start pulses while active are dropped
				line_active <= 1'b1;
				idx         <= '0;
			end
		end else if (cmd_ready) begin
			if (idx == IDX_LAST) begin
				line_active <= 1'b0;
			end else begin
				idx <= idx + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!line_active && line_start) begin
			buf_q <= line_buf;
			sel_q <= line_sel;
		end
	end

endmodule

// ==== src/lcd_top.sv ====
module lcd_top (
	input  logic        clk,
	input  logic        rst,
	input  logic        awvalid,
	input  logic [4:0]  awaddr,
	input  logic        wvalid,
	input  logic [31:0] wdata,
	input  logic [3:0]  wstrb,
	input  logic        bready,
	input  logic        arvalid,
	input  logic [4:0]  araddr,
	input  logic        rready,
	output logic        awready,
	output logic        wready,
	output logic        bvalid,
	output logic [1:0]  bresp,
	output logic        arready,
	output logic        rvalid,
	output logic [31:0] rdata,
	output logic [1:0]  rresp,
	output logic        e,
	output logic        rs,
	output logic        rw,
	output logic [7:0]  lcd_data
);
	import lcd_pkg::*;

	lcd_cfg_t  cfg;
	lcd_cmd_t  cmd_req;
	lcd_cmd_t  line_cmd;
	lcd_cmd_t  eng_cmd;
	lcd_line_t line_buf;
	logic      cmd_req_valid;
	logic      cmd_req_ready;
	logic      line_cmd_valid;
	logic      line_cmd_ready;
	logic      line_sel;
	logic      line_start;
	logic      line_active;
	logic      eng_valid;
	logic      eng_ready;
	logic      init_done;
	logic      busy;

	lcd_axil_regs u_regs (
		.clk(clk), .rst(rst),
		.awvalid(awvalid), .awaddr(awaddr), .wvalid(wvalid), .wdata(wdata), .wstrb(wstrb),
		.bready(bready), .arvalid(arvalid), .araddr(araddr), .rready(rready),
		.cmd_req_ready(cmd_req_ready), .init_done(init_done), .busy(busy),
		.line_active(line_active),
		.awready(awready), .wready(wready), .bvalid(bvalid), .bresp(bresp),
		.arready(arready), .rvalid(rvalid), .rdata(rdata), .rresp(rresp),
		.cfg(cfg), .cmd_req_valid(cmd_req_valid), .cmd_req(cmd_req),
		.line_buf(line_buf), .line_sel(line_sel), .line_start(line_start)
	);

	lcd_line_writer u_writer (
		.clk(clk), .rst(rst),
		.line_buf(line_buf), .line_sel(line_sel), .line_start(line_start),
		.cmd_ready(line_cmd_ready), .cmd_valid(line_cmd_valid), .cmd(line_cmd),
		.line_active(line_active)
	);

	// requester 0 is the register block, 1 the line writer
	lcd_cmd_arbiter u_arb (
		.clk(clk), .rst(rst),
		.req_valid({line_cmd_valid, cmd_req_valid}), .req_cmd({line_cmd, cmd_req}),
		.eng_ready(eng_ready), .req_ready({line_cmd_ready, cmd_req_ready}),
		.eng_valid(eng_valid), .eng_cmd(eng_cmd)
	);

	lcd_hd44780_ctrl u_ctrl (
		.clk(clk), .rst(rst), .cfg(cfg),
		.eng_valid(eng_valid), .eng_cmd(eng_cmd), .eng_ready(eng_ready),
		.init_done(init_done), .busy(busy),
		.e(e), .rs(rs), .rw(rw), .lcd_data(lcd_data)
	);

endmodule

// ==== verification/lcd_bus_monitor.sv ====
module lcd_bus_monitor (
	input logic       clk,
	input logic       e,
	input logic       rs,
	input logic       rw,
	input logic [7:0] lcd_data
);
	timeunit 1ns;
	timeprecision 1ps;
	import lcd_pkg::*;

	lcd_cmd_t cmds[$];    // oldest command first
	logic     e_q;

	// falling edge of e seen at the clock, bus still holds the command
	always @(posedge clk) begin
		e_q <= e;
		if (e_q === 1'b1 && e === 1'b0) begin
			cmds.push_back({rs, rw, lcd_data});
		end
	end

	function automatic int count();
		return cmds.size();
	endfunction

	function automatic lcd_cmd_t pop_cmd();
		return cmds.pop_front();
	endfunction

endmodule

// ==== verification/lcd_tb.sv ====
`include "lcd_defs.svh"

module lcd_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import lcd_pkg::*;

	localparam int CLK_PERIOD  = 100;
	localparam int T           = `LCD_CLK_PER_US;
	localparam int PWR_CYC     = `LCD_T_POWERUP * T;
	localparam int INIT_CYC    = (4 * `LCD_T_INIT_E + 2 * `LCD_T_CMD + `LCD_T_CLEAR
		+ `LCD_T_ENTRY) * T;
	localparam int CMD_CYC     = `LCD_T_CMD * T + 2;   // window plus idle turnaround
	localparam int N_CMDS      = 2 * (`LCD_LINE_CHARS + 1) + 2;
	localparam int HS_LIMIT    = 4 * CMD_CYC;
	localparam int WAIT_LIMIT  = PWR_CYC + INIT_CYC;
	localparam int TIMEOUT_CYC = PWR_CYC + INIT_CYC + N_CMDS * CMD_CYC + 2000;

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	logic        clk;
	logic        rst;
	logic        awvalid;
	logic [4:0]  awaddr;
	logic        wvalid;
	logic [31:0] wdata;
	logic [3:0]  wstrb;
	logic        bready;
	logic        arvalid;
	logic [4:0]  araddr;
	logic        rready;
	logic        awready;
	logic        wready;
	logic        bvalid;
	logic [1:0]  bresp;
	logic        arready;
	logic        rvalid;
	logic [31:0] rdata;
	logic [1:0]  rresp;
	logic        e;
	logic        rs;
	logic        rw;
	logic [7:0]  lcd_data;

	int          errors = 0;
	int          checks = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	int          test_err0;
	logic [31:0] lcg_state = 32'd49254;

	lcd_top dut (
		.clk(clk), .rst(rst),
		.awvalid(awvalid), .awaddr(awaddr), .wvalid(wvalid), .wdata(wdata), .wstrb(wstrb),
		.bready(bready), .arvalid(arvalid), .araddr(araddr), .rready(rready),
		.awready(awready), .wready(wready), .bvalid(bvalid), .bresp(bresp),
		.arready(arready), .rvalid(rvalid), .rdata(rdata), .rresp(rresp),
		.e(e), .rs(rs), .rw(rw), .lcd_data(lcd_data)
	);

	lcd_bus_monitor mon (.clk(clk), .e(e), .rs(rs), .rw(rw), .lcd_data(lcd_data));

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		int cycles;
		cycles = 0;
		while (cycles < TIMEOUT_CYC) begin
			@(posedge clk);
			cycles++;
		end
		$display("%0t: run stopped after %0d cycles without finishing", $time, cycles);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	function automatic lcd_cmd_t make_cmd(input logic c_rs, input logic c_rw,
		input logic [7:0] c_data);
		lcd_cmd_t c;
		c.rs   = c_rs;
		c.rw   = c_rw;
		c.data = c_data;
		return c;
	endfunction

	// address command first, then the characters
	function automatic lcd_cmd_t line_cmd_at(input logic sel, input lcd_line_t chars,
		input int idx);
		if (idx == 0) return make_cmd(1'b0, 1'b0, sel ? 8'hC0 : 8'h80);
		return make_cmd(1'b1, 1'b0, chars[idx - 1]);
	endfunction

	function automatic lcd_line_t random_line();
		lcd_line_t   l;
		logic [31:0] r;
		for (int k = 0; k < `LCD_LINE_CHARS; k++) begin
			r    = lcg_next();
			l[k] = r[23:16];
		end
		return l;
	endfunction

	task automatic check_cmd(input lcd_cmd_t got, input lcd_cmd_t exp, input string msg);
		checks++;
		if (got !== exp) begin
			$display("MISMATCH %0t: %s got rs=%b rw=%b data=%02h, expected rs=%b rw=%b data=%02h",
				$time, msg, got.rs, got.rw, got.data, exp.rs, exp.rw, exp.data);
			errors++;
		end
	endtask

	task automatic check_cfg(input lcd_cfg_t got, input lcd_cfg_t exp, input string msg);
		checks++;
		if (got !== exp) begin
			$display("MISMATCH %0t: %s got %07b, expected %07b", $time, msg, got, exp);
			errors++;
		end
	endtask

	task automatic check_status(input lcd_status_t got, input lcd_status_t exp,
		input string msg);
		checks++;
		if (got !== exp) begin
			$display("MISMATCH %0t: %s got init_done=%b busy=%b line_active=%b, expected %03b",
				$time, msg, got.init_done, got.busy, got.line_active, exp);
			errors++;
		end
	endtask

	task automatic check_resp(input logic [1:0] got, input logic [1:0] exp, input string msg);
		checks++;
		if (got !== exp) begin
			$display("MISMATCH %0t: %s got resp %02b, expected %02b", $time, msg, got, exp);
			errors++;
		end
	endtask

	// mid low phase, outputs settled until the next rising edge
	task automatic wait_settled();
		#(CLK_PERIOD / 4);
	endtask

	task automatic axi_write(input logic [4:0] addr, input logic [31:0] data,
		output logic [1:0] resp);
		int n;
		bit ok;
		@(negedge clk);
		awvalid = 1'b1;
		awaddr  = addr;
		wvalid  = 1'b1;
		wdata   = data;
		bready  = 1'b1;
		n = 0;
		wait_settled();
		while (!(awready && wready) && n < HS_LIMIT) begin
			@(negedge clk);
			wait_settled();
			n++;
		end
		ok = awready && wready;
		@(negedge clk);
		awvalid = 1'b0;
		wvalid  = 1'b0;
		resp    = 2'b11;
		if (!ok) begin
			$display("%0t: write to 0x%02h was never accepted", $time, addr);
			errors++;
			bready = 1'b0;
			return;
		end
		n = 0;
		wait_settled();
		while (!bvalid && n < HS_LIMIT) begin   // CMD writes wait for the arbiter
			@(negedge clk);
			wait_settled();
			n++;
		end
		ok   = bvalid;
		resp = bresp;
		@(negedge clk);
		bready = 1'b0;
		if (!ok) begin
			$display("%0t: write to 0x%02h got no response", $time, addr);
			errors++;
		end
	endtask

	task automatic axi_read(input logic [4:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		int n;
		bit ok;
		@(negedge clk);
		arvalid = 1'b1;
		araddr  = addr;
		rready  = 1'b1;
		n = 0;
		wait_settled();
		while (!arready && n < HS_LIMIT) begin
			@(negedge clk);
			wait_settled();
			n++;
		end
		@(negedge clk);
		arvalid = 1'b0;
		n = 0;
		wait_settled();
		while (!rvalid && n < HS_LIMIT) begin
			@(negedge clk);
			wait_settled();
			n++;
		end
		ok   = rvalid;
		data = rdata;
		resp = rresp;
		@(negedge clk);
		rready = 1'b0;
		if (!ok) begin
			$display("%0t: read from 0x%02h got no data", $time, addr);
			errors++;
			resp = 2'b11;
		end
	endtask

	task automatic next_cmd(output lcd_cmd_t c, output bit ok);
		int n;
		n = 0;
		while (mon.count() == 0 && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		ok = (mon.count() != 0);
		c  = '0;
		if (ok) begin
			c = mon.pop_cmd();
		end else begin
			$display("%0t: no command appeared on the LCD bus", $time);
			errors++;
		end
	endtask

	task automatic expect_cmd(input lcd_cmd_t exp, input string msg);
		lcd_cmd_t got;
		bit       ok;
		next_cmd(got, ok);
		if (ok) check_cmd(got, exp, msg);
	endtask

	task automatic check_bus_quiet(input string msg);
		if (mon.count() != 0) begin
			$display("%0t: %s left %0d extra commands on the LCD bus", $time, msg, mon.count());
			errors++;
		end
	endtask

	task automatic wait_idle(output lcd_status_t st);
		logic [31:0] data;
		logic [1:0]  resp;
		int          n;
		n = 0;
		do begin
			axi_read(`LCD_ADDR_STATUS, data, resp);
			st = lcd_status_t'(data[2:0]);
			n++;
		end while ((st.busy || st.line_active) && n < INIT_CYC);
		if (st.busy || st.line_active) begin
			$display("%0t: display controller never went idle", $time);
			errors++;
		end
	endtask

	task automatic load_line(input lcd_line_t chars);
		logic [1:0] resp;
		for (int w = 0; w < `LCD_LINE_CHARS / 4; w++) begin
			axi_write(`LCD_ADDR_CHAR0 + 5'(4 * w), chars[4 * w +: 4], resp);
			check_resp(resp, RESP_OKAY, "char word write");
		end
	endtask

	task automatic start_test();
		test_err0 = errors;
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (errors == test_err0) begin
			$display("%0t: %s passed", $time, name);
		end else begin
			tests_failed++;
			$display("%0t: %s failed with %0d errors", $time, name, errors - test_err0);
		end
	endtask

	task automatic test_init();
		lcd_cfg_t    c;
		lcd_status_t st;
		lcd_status_t exp_st;
		start_test();
		c = lcd_cfg_t'(`LCD_CFG_DEFAULT);
		expect_cmd(make_cmd(1'b0, 1'b0, 8'h30 | {4'b0, c.two_line, c.font, 2'b00}),
			"function set");
		expect_cmd(make_cmd(1'b0, 1'b0, 8'h08 | {5'b0, c.display_on, c.cursor_on, c.blink_on}),
			"display control");
		expect_cmd(make_cmd(1'b0, 1'b0, 8'h01), "clear");
		expect_cmd(make_cmd(1'b0, 1'b0, 8'h04 | {6'b0, c.increment, c.shift}), "entry mode");
		wait_idle(st);
		exp_st.init_done   = 1'b1;
		exp_st.busy        = 1'b0;
		exp_st.line_active = 1'b0;
		check_status(st, exp_st, "status after init");
		check_bus_quiet("init");
		finish_test("initialization");
	endtask

	task automatic test_cfg();
		logic [31:0] r;
		logic [1:0]  resp;
		lcd_cfg_t    c;
		start_test();
		r = lcg_next();
		c = lcd_cfg_t'(r[22:16]);
		axi_write(`LCD_ADDR_CFG, {25'd0, c}, resp);
		check_resp(resp, RESP_OKAY, "cfg write");
		axi_read(`LCD_ADDR_CFG, r, resp);
		check_resp(resp, RESP_OKAY, "cfg read");
		check_cfg(lcd_cfg_t'(r[6:0]), c, "cfg readback");
		finish_test("configuration readback");
	endtask

	task automatic test_raw_cmd();
		logic [31:0] r;
		logic [1:0]  resp;
		lcd_cmd_t    c;
		lcd_status_t st;
		start_test();
		r = lcg_next();
		c = lcd_cmd_t'(r[25:16]);
		axi_write(`LCD_ADDR_CMD, {22'd0, c}, resp);
		check_resp(resp, RESP_OKAY, "cmd write");
		expect_cmd(c, "raw command");
		wait_idle(st);
		check_bus_quiet("raw command");
		finish_test("raw command");
	endtask

	task automatic test_line_write();
		lcd_line_t   chars;
		logic [1:0]  resp;
		lcd_status_t st;
		start_test();
		chars = random_line();
		load_line(chars);
		axi_write(`LCD_ADDR_LINE, 32'h3, resp);   // start, line 1
		check_resp(resp, RESP_OKAY, "line start write");
		for (int idx = 0; idx <= `LCD_LINE_CHARS; idx++) begin
			expect_cmd(line_cmd_at(1'b1, chars, idx), $sformatf("line 1 command %0d", idx));
		end
		wait_idle(st);
		check_bus_quiet("line write");
		finish_test("line write");
	endtask

	task automatic test_arbitration();
		lcd_line_t   chars;
		logic [31:0] r;
		logic [1:0]  resp;
		lcd_cmd_t    raw;
		lcd_cmd_t    got;
		lcd_status_t st;
		bit          ok;
		int          raw_pos;
		int          idx;
		start_test();
		chars = random_line();
		load_line(chars);
		r   = lcg_next();
		raw = make_cmd(1'b0, 1'b1, r[23:16]);   // rw high, unlike any line command
		axi_write(`LCD_ADDR_LINE, 32'h1, resp);
		check_resp(resp, RESP_OKAY, "line start write");
		axi_write(`LCD_ADDR_CMD, {22'd0, raw}, resp);
		check_resp(resp, RESP_OKAY, "cmd write during line");
		raw_pos = -1;
		idx     = 0;
		for (int k = 0; k < `LCD_LINE_CHARS + 2; k++) begin
			next_cmd(got, ok);
			if (!ok) break;
			if (got.rw) begin
				raw_pos = k;
				check_cmd(got, raw, "raw command during line");
			end else if (idx > `LCD_LINE_CHARS) begin
				$display("%0t: line writer sent more commands than one line holds", $time);
				errors++;
			end else begin
				check_cmd(got, line_cmd_at(1'b0, chars, idx), $sformatf("line 0 command %0d", idx));
				idx++;
			end
		end
		checks++;
		if (raw_pos < 0) begin
			$display("%0t: raw command never reached the LCD bus", $time);
			errors++;
		end else if (raw_pos > 1) begin
			$display("MISMATCH %0t: raw command at position %0d, expected at most 1",
				$time, raw_pos);
			errors++;
		end
		wait_idle(st);
		check_bus_quiet("arbitration");
		finish_test("arbitration");
	endtask

	task automatic test_unmapped();
		logic [31:0] data;
		logic [1:0]  resp;
		start_test();
		axi_read(5'h06, data, resp);
		check_resp(resp, RESP_SLVERR, "unmapped read");
		axi_write(5'h13, 32'hA5A5_A5A5, resp);
		check_resp(resp, RESP_SLVERR, "unmapped write");
		finish_test("unmapped address");
	endtask

	initial begin
		rst     = 1'b1;
		awvalid = 1'b0;
		awaddr  = '0;
		wvalid  = 1'b0;
		wdata   = '0;
		wstrb   = 4'hF;
		bready  = 1'b0;
		arvalid = 1'b0;
		araddr  = '0;
		rready  = 1'b0;
		repeat (5) @(negedge clk);
		rst = 1'b0;

		test_init();
		test_cfg();
		test_raw_cmd();
		test_line_write();
		test_arbitration();
		test_unmapped();

		$display("tests %0d, passed %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_run - tests_failed, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+src
src/lcd_pkg.sv
src/lcd_hd44780_ctrl.sv
src/lcd_cmd_arbiter.sv
src/lcd_axil_regs.sv
src/lcd_line_writer.sv
src/lcd_top.sv
verification/lcd_bus_monitor.sv
verification/lcd_tb.sv
